// ==== source/stepper_pkg.sv ====
// Stepper driver package with the shared widths and the gate and timer structs
package stepper_pkg;

  // Counter widths for the per-coil chopping timers
  localparam int blank_w  = 8;
  localparam int off_w    = 10;
  localparam int min_on_w = 8;

  // Width of one coil current reference for the DAC
  localparam int level_w  = 8;

  // High and low gate of each of the four half-bridges
  typedef struct packed {
    logic a1_h;
    logic a1_l;
    logic a2_h;
    logic a2_l;
    logic b1_h;
    logic b1_l;
    logic b2_h;
    logic b2_l;
  } bridge_gates_t;

  // Static timer lengths, in clock cycles
  typedef struct packed {
    logic [blank_w-1:0]  blank_len;
    logic [off_w-1:0]    off_len;
    logic [min_on_w-1:0] min_on_len;
  } timer_cfg_t;

  // Live counts of one coil's timers
  typedef struct packed {
    logic [blank_w-1:0]  blank;
    logic [off_w-1:0]    off;
    logic [min_on_w-1:0] min_on;
  } timer_state_t;

endpackage

// ==== source/step_commutation.sv ====
// Step/direction phase counter with quarter-sine commutation for two coils
`timescale 1ns/1ps

module step_commutation #(
  parameter int phase_bits = 8
) (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic                            step,
  input  logic                            dir,
  output logic [phase_bits-1:0]           phase_ct,
  output logic [3:0]                      s,
  output logic [stepper_pkg::level_w-1:0] level_a,
  output logic [stepper_pkg::level_w-1:0] level_b
);

  localparam int level_w   = stepper_pkg::level_w;
  localparam int level_max = (1 << level_w) - 1;
  // Microsteps per quadrant
  localparam int q_w       = phase_bits - 2;
  localparam int quarter   = 1 << q_w;

  // One entry per microstep in a quadrant, both ends included
  typedef logic [quarter:0][level_w-1:0] sine_tab_t;

  // Bhaskara approximation of sin(pi/2 * k/quarter), scaled to level_max
  function automatic sine_tab_t build_sine_tab();
    sine_tab_t tab;
    longint    p;
    longint    num;
    longint    den;
    for (int k = 0; k <= quarter; k++) begin
      p   = longint'(k) * longint'(2 * quarter - k);
      num = longint'(level_max) * 16 * p;
      den = 20 * longint'(quarter) * longint'(quarter) - 4 * p;
      tab[k] = level_w'((num + den / 2) / den);
    end
    return tab;
  endfunction

  localparam sine_tab_t sine_tab = build_sine_tab();

  logic [2:0]     step_r;
  logic [1:0]     dir_r;
  logic           step_rise;
  logic [1:0]     quad;
  logic [q_w:0]   low;
  logic [q_w:0]   mirr;
  logic [q_w:0]   idx_a;
  logic [q_w:0]   idx_b;

  // Edge detect on the last two sync stages, dir_r[1] lines up with step_r[1]
  assign step_rise = step_r[1] & ~step_r[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_r   <= '0;
      dir_r    <= '0;
      phase_ct <= '0;
    end else begin
      step_r <= {step_r[1:0], step};
      dir_r  <= {dir_r[0], dir};
      if (step_rise) begin
        phase_ct <= dir_r[1] ? phase_ct + 1'b1 : phase_ct - 1'b1;
      end
    end
  end

  assign quad = phase_ct[phase_bits-1 -: 2];
  assign low  = {1'b0, phase_ct[q_w-1:0]};
  assign mirr = {1'b1, {q_w{1'b0}}} - low;

  // Coil B follows the sine, coil A the cosine
  assign idx_b = quad[0] ? mirr : low;
  assign idx_a = quad[0] ? low : mirr;

  assign level_a = sine_tab[idx_a];
  assign level_b = sine_tab[idx_b];

  // Bit order a1, a2, b1, b2 from bit 0 upward
  // A positive in quadrants 0 and 3, B positive in quadrants 0 and 1
  assign s[0] = (quad[1] == quad[0]);
  assign s[1] = (quad[1] != quad[0]);
  assign s[2] = ~quad[1];
  assign s[3] = quad[1];

endmodule

// ==== source/coil_timers.sv ====
// Off, blanking and minimum-on down-counters for the chopper of one coil
`timescale 1ns/1ps

module coil_timers (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      offtimer_en,
  input  stepper_pkg::timer_cfg_t   cfg,
  output stepper_pkg::timer_state_t state
);

  localparam int blank_w  = stepper_pkg::blank_w;
  localparam int off_w    = stepper_pkg::off_w;
  localparam int min_on_w = stepper_pkg::min_on_w;

  logic off_last;

  // Final cycle of the off time, blanking and min-on restart on the next edge
  assign off_last = (state.off == off_w'(1));

  // Off time loads on a start strobe and runs down to zero
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state.off <= '0;
    end else if (offtimer_en) begin
      state.off <= cfg.off_len;
    end else if (state.off != '0) begin
      state.off <= state.off - off_w'(1);
    end
  end

  // Blanking hides the comparator while the bridge current settles
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state.blank <= '0;
    end else if (off_last) begin
      state.blank <= cfg.blank_len;
    end else if (state.blank != '0) begin
      state.blank <= state.blank - blank_w'(1);
    end
  end

  // Minimum on time, a new off time before it expires is a fault
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state.min_on <= '0;
    end else if (off_last) begin
      state.min_on <= cfg.min_on_len;
    end else if (state.min_on != '0) begin
      state.min_on <= state.min_on - min_on_w'(1);
    end
  end

endmodule

// ==== source/microstep_control.sv ====
// Mixed-decay gate control with enable, fault latch, inversion and off-timer starts
`timescale 1ns/1ps

module microstep_control (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           enable_in,
  input  logic [3:0]                     s,
  input  stepper_pkg::timer_state_t      state_a,
  input  stepper_pkg::timer_state_t      state_b,
  input  logic                           analog_cmp_a,
  input  logic                           analog_cmp_b,
  input  logic [stepper_pkg::off_w-1:0]  fastdecay_threshold,
  input  logic                           invert_highside,
  input  logic                           invert_lowside,
  output stepper_pkg::bridge_gates_t     gates,
  output logic                           faultn,
  output logic                           offtimer_en_a,
  output logic                           offtimer_en_b
);

  logic       enable;
  logic       fault_a;
  logic       fault_b;
  logic [1:0] fast;
  logic [1:0] slow;
  logic [3:0] hi;
  logic [3:0] lo;
  // Gate controls before output inversion, active high
  logic [3:0] hi_ctl;
  logic [3:0] lo_ctl;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable <= 1'b0;
    end else begin
      enable <= enable_in;
    end
  end

  // Off time running while the minimum on time has not expired
  assign fault_a = (state_a.off != '0) && (state_a.min_on != '0);
  assign fault_b = (state_b.off != '0) && (state_b.min_on != '0);

  // Latched until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (enable && (fault_a || fault_b)) begin
      faultn <= 1'b0;
    end
  end

  // Fast decay for the start of the off time, slow decay for the rest
  assign fast[0] = (state_a.off >= fastdecay_threshold);
  assign fast[1] = (state_b.off >= fastdecay_threshold);
  assign slow[0] = (state_a.off != '0) && !fast[0];
  assign slow[1] = (state_b.off != '0) && !fast[1];

  // Bridges 0,1 belong to coil A and 2,3 to coil B
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (slow[i/2]) begin
        hi[i] = 1'b0;
        lo[i] = 1'b1;
      end else if (fast[i/2]) begin
        hi[i] = ~s[i];
        lo[i] = s[i];
      end else begin
        hi[i] = s[i];
        lo[i] = ~s[i];
      end
    end
  end

  // Disabled bridges brake on the low sides
  assign lo_ctl = lo | {4{~enable}};
  assign hi_ctl = hi & {4{enable & faultn}};

  assign gates.a1_h = invert_highside ^ hi_ctl[0];
  assign gates.a2_h = invert_highside ^ hi_ctl[1];
  assign gates.b1_h = invert_highside ^ hi_ctl[2];
  assign gates.b2_h = invert_highside ^ hi_ctl[3];
  assign gates.a1_l = invert_lowside ^ lo_ctl[0];
  assign gates.a2_l = invert_lowside ^ lo_ctl[1];
  assign gates.b1_l = invert_lowside ^ lo_ctl[2];
  assign gates.b2_l = invert_lowside ^ lo_ctl[3];

  // Peak current reached outside blanking and outside an off time
  assign offtimer_en_a = analog_cmp_a && (state_a.blank == '0) && (state_a.off == '0);
  assign offtimer_en_b = analog_cmp_b && (state_b.blank == '0) && (state_b.off == '0);

endmodule

// ==== source/microstepper_top.sv ====
// Two-coil chopping stepper driver core with step/dir input and gate outputs
`timescale 1ns/1ps

module microstepper_top #(
  parameter int phase_bits = 8
) (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic                            step,
  input  logic                            dir,
  input  logic                            enable_in,
  input  logic                            analog_cmp_a,
  input  logic                            analog_cmp_b,
  input  stepper_pkg::timer_cfg_t         timer_cfg,
  input  logic [stepper_pkg::off_w-1:0]   fastdecay_threshold,
  input  logic                            invert_highside,
  input  logic                            invert_lowside,
  output stepper_pkg::bridge_gates_t      gates,
  output logic                            faultn,
  output logic [phase_bits-1:0]           phase_ct,
  output logic [stepper_pkg::level_w-1:0] level_a,
  output logic [stepper_pkg::level_w-1:0] level_b
);

  logic [3:0]                s;
  stepper_pkg::timer_state_t state_a;
  stepper_pkg::timer_state_t state_b;
  logic                      offtimer_en_a;
  logic                      offtimer_en_b;

  step_commutation #(
    .phase_bits (phase_bits)
  ) u_step_commutation (
    .clk      (clk),
    .resetn   (resetn),
    .step     (step),
    .dir      (dir),
    .phase_ct (phase_ct),
    .s        (s),
    .level_a  (level_a),
    .level_b  (level_b)
  );

  // Both coils share one timer configuration
  coil_timers u_timers_a (
    .clk         (clk),
    .resetn      (resetn),
    .offtimer_en (offtimer_en_a),
    .cfg         (timer_cfg),
    .state       (state_a)
  );

  coil_timers u_timers_b (
    .clk         (clk),
    .resetn      (resetn),
    .offtimer_en (offtimer_en_b),
    .cfg         (timer_cfg),
    .state       (state_b)
  );

  microstep_control u_microstep_control (
    .clk                 (clk),
    .resetn              (resetn),
    .enable_in           (enable_in),
    .s                   (s),
    .state_a             (state_a),
    .state_b             (state_b),
    .analog_cmp_a        (analog_cmp_a),
    .analog_cmp_b        (analog_cmp_b),
    .fastdecay_threshold (fastdecay_threshold),
    .invert_highside     (invert_highside),
    .invert_lowside      (invert_lowside),
    .gates               (gates),
    .faultn              (faultn),
    .offtimer_en_a       (offtimer_en_a),
    .offtimer_en_b       (offtimer_en_b)
  );

endmodule

// ==== sim/microstepper_assertions.sv ====
// Bound checker for bridge shoot-through, fault shutdown and disable braking
`timescale 1ns/1ps

module microstepper_assertions (
  input logic                       clk,
  input logic                       resetn,
  input logic                       enable,
  input logic                       faultn,
  input logic                       invert_highside,
  input logic                       invert_lowside,
  input stepper_pkg::bridge_gates_t gates
);

  // Failure counts per rule
  int shoot_fails   = 0;
  int fault_fails   = 0;
  int disable_fails = 0;

  // Gate levels at the outputs with the inversion undone, bit order a1, a2, b1, b2
  logic [3:0] hi_on;
  logic [3:0] lo_on;

  assign hi_on = {gates.b2_h, gates.b1_h, gates.a2_h, gates.a1_h} ^ {4{invert_highside}};
  assign lo_on = {gates.b2_l, gates.b1_l, gates.a2_l, gates.a1_l} ^ {4{invert_lowside}};

  // Never both switches of one half-bridge
  no_shoot_through: assert property (@(posedge clk) disable iff (!resetn)
    (hi_on & lo_on) == 4'b0000)
  else begin
    shoot_fails++;
    $error("Half-bridge with both sides on, hi %b lo %b", hi_on, lo_on);
  end

  // A latched fault keeps every high side off
  fault_shutdown: assert property (@(posedge clk) disable iff (!resetn)
    !faultn |-> hi_on == 4'b0000)
  else begin
    fault_fails++;
    $error("High side on while a fault is latched, hi %b", hi_on);
  end

  // Disabled driver brakes on all low sides
  disable_brake: assert property (@(posedge clk) disable iff (!resetn)
    !enable |-> lo_on == 4'b1111)
  else begin
    disable_fails++;
    $error("Low side off while the driver is disabled, lo %b", lo_on);
  end

endmodule

bind microstep_control microstepper_assertions u_assertions (
  .clk             (clk),
  .resetn          (resetn),
  .enable          (enable),
  .faultn          (faultn),
  .invert_highside (invert_highside),
  .invert_lowside  (invert_lowside),
  .gates           (gates)
);

// ==== sim/tb_microstepper.sv ====
// Testbench for the stepper core covering stepping, commutation, chopping, faults and inversion
`timescale 1ns/1ps

module tb_microstepper;

  localparam int clk_period = 10;
  // Summed cycle budgets of the five tests plus a margin
  localparam int budget_cycles = 450 + 1350 + 60 + 200 + 60 + 500;
  localparam logic [stepper_pkg::off_w-1:0] fast_thr = 10'd28;
  localparam stepper_pkg::timer_cfg_t chop_cfg =
    '{blank_len: 8'd6, off_len: 10'd40, min_on_len: 8'd4};
  localparam stepper_pkg::timer_cfg_t fault_cfg =
    '{blank_len: 8'd3, off_len: 10'd8, min_on_len: 8'd20};
  localparam real pi = 3.14159265358979;

  logic                            clk = 1'b0;
  logic                            resetn;
  logic                            step;
  logic                            dir;
  logic                            enable_in;
  logic                            analog_cmp_a;
  logic                            analog_cmp_b;
  stepper_pkg::timer_cfg_t         timer_cfg;
  logic [stepper_pkg::off_w-1:0]   fastdecay_threshold;
  logic                            invert_highside;
  logic                            invert_lowside;
  stepper_pkg::bridge_gates_t      gates;
  logic                            faultn;
  logic [7:0]                      phase_ct;
  logic [stepper_pkg::level_w-1:0] level_a;
  logic [stepper_pkg::level_w-1:0] level_b;
  logic [7:0]                      model_phase = 8'd0;
  int                              errors = 0;

  microstepper_top u_microstepper_top (.*);

  always #(clk_period / 2) clk = ~clk;

  initial begin
    #(budget_cycles * clk_period);
    $display("Watchdog expired after %0d cycles before the tests finished", budget_cycles);
    $display("TB FAILED");
    $finish;
  end

  // Expected gates from the quadrant, decay and shutdown rules
  function automatic stepper_pkg::bridge_gates_t model_gates(input logic [7:0] phase,
      input int off_a, input logic en, input logic ok, input logic [1:0] inv);
    logic [3:0] pol;
    logic [3:0] hi;
    logic [3:0] lo;
    int         off;
    pol[0] = (phase[7:6] == 2'd0) || (phase[7:6] == 2'd3);
    pol[1] = ~pol[0];
    pol[2] = (phase[7:6] <= 2'd1);
    pol[3] = ~pol[2];
    for (int i = 0; i < 4; i++) begin
      off   = (i < 2) ? off_a : 0;
      hi[i] = (off == 0) ? pol[i] : ((off >= int'(fast_thr)) ? ~pol[i] : 1'b0);
      lo[i] = (off == 0) ? ~pol[i] : ((off >= int'(fast_thr)) ? pol[i] : 1'b1);
      hi[i] = hi[i] & en & ok;
      lo[i] = lo[i] | ~en;
    end
    hi = hi ^ {4{inv[0]}};
    lo = lo ^ {4{inv[1]}};
    return '{hi[0], lo[0], hi[1], lo[1], hi[2], lo[2], hi[3], lo[3]};
  endfunction

  // Full-scale magnitude of the cosine or sine of the electrical angle
  function automatic int ideal_level(input logic [7:0] phase, input logic cosine);
    real ang;
    real v;
    ang = 2.0 * pi * real'(phase) / 256.0;
    v   = cosine ? $cos(ang) : $sin(ang);
    if (v < 0.0) begin
      v = -v;
    end
    return int'(v * real'((1 << stepper_pkg::level_w) - 1));
  endfunction

  task automatic compare_gates(input stepper_pkg::bridge_gates_t exp);
    assert (gates == exp) else begin
      $display("Mismatch at %0d ns: gates expected %b got %b", $time, exp, gates);
      errors++;
    end
  endtask

  task automatic compare_value(input string name, input logic [15:0] got,
      input logic [15:0] exp);
    assert (got == exp) else begin
      $display("Mismatch at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // One LSB of slack for the table approximation of the sine
  task automatic check_level(input string name, input int got, input int exp);
    assert (got <= exp + 1 && got + 1 >= exp) else begin
      $display("Mismatch at %0d ns: %s expected %0d got %0d", $time, name, exp, got);
      errors++;
    end
  endtask

  // One step pulse, high two cycles and low three before the next
  task automatic pulse_step(input logic d);
    @(posedge clk);
    dir  <= d;
    step <= 1'b1;
    repeat (2) @(posedge clk);
    step <= 1'b0;
    repeat (2) @(posedge clk);
    model_phase = d ? model_phase + 8'd1 : model_phase - 8'd1;
  endtask

  task automatic reset_dut();
    resetn <= 1'b0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    model_phase = 8'd0;
  endtask

  task automatic finish_test(input string name, input int mark);
    $display("Test %s finished with %0d errors", name, errors - mark);
  endtask

  initial begin
    int n;
    int mark;
    int asserts_failed;
    void'($urandom(32'h4e9b_91bf));
    resetn              = 1'b0;
    step                = 1'b0;
    dir                 = 1'b0;
    enable_in           = 1'b1;
    analog_cmp_a        = 1'b0;
    analog_cmp_b        = 1'b0;
    timer_cfg           = chop_cfg;
    fastdecay_threshold = fast_thr;
    invert_highside     = 1'b0;
    invert_lowside      = 1'b0;
    reset_dut();

    mark = errors;
    for (int b = 0; b < 5; b++) begin
      n = $urandom_range(16, 1);
      repeat (n) pulse_step($urandom_range(1, 0) != 0);
      @(negedge clk);
      compare_value("phase_ct", 16'(phase_ct), 16'(model_phase));
      check_level("level_a", int'(level_a), ideal_level(model_phase, 1'b1));
      check_level("level_b", int'(level_b), ideal_level(model_phase, 1'b0));
    end
    finish_test("step counting", mark);

    // Walk to the middle of four consecutive quadrants
    mark = errors;
    for (int q = 0; q < 4; q++) begin
      pulse_step(1'b1);
      while (model_phase[5:0] != 6'd32) pulse_step(1'b1);
      @(negedge clk);
      compare_gates(model_gates(model_phase, 0, 1'b1, 1'b1, 2'b00));
    end
    finish_test("commutation polarity", mark);

    mark = errors;
    n = int'(chop_cfg.off_len);
    @(posedge clk);
    analog_cmp_a <= 1'b1;
    @(posedge clk);
    for (int k = 0; k <= n + 4; k++) begin
      @(negedge clk);
      compare_gates(model_gates(model_phase, (k <= n) ? n - k : 0, 1'b1, 1'b1, 2'b00));
      @(posedge clk);
      if (k == n) analog_cmp_a <= 1'b0;
    end
    finish_test("chopping sequence", mark);

    mark = errors;
    timer_cfg <= fault_cfg;
    repeat (10) @(posedge clk);
    analog_cmp_a <= 1'b1;
    n = 0;
    while (faultn && n < 100) begin
      @(negedge clk);
      n++;
    end
    assert (!faultn) else begin
      $display("faultn stayed high although the off time restarted inside the min on time");
      errors++;
    end
    compare_value("high gates", 16'({gates.a1_h, gates.a2_h, gates.b1_h, gates.b2_h}), 16'd0);
    @(posedge clk);
    analog_cmp_a <= 1'b0;
    repeat (30) @(posedge clk);
    @(negedge clk);
    compare_value("faultn", 16'(faultn), 16'd0);
    @(posedge clk);
    reset_dut();
    @(negedge clk);
    compare_value("faultn", 16'(faultn), 16'd1);
    compare_value("phase_ct", 16'(phase_ct), 16'(model_phase));
    finish_test("fault latch", mark);

    // Bit 2 is the enable, bits 1 and 0 the low and high inversion
    mark = errors;
    @(posedge clk);
    timer_cfg <= chop_cfg;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      enable_in       <= i[2];
      invert_highside <= i[0];
      invert_lowside  <= i[1];
      @(posedge clk);
      @(negedge clk);
      compare_gates(model_gates(model_phase, 0, i[2], 1'b1, 2'(i)));
    end
    finish_test("disable and inversion", mark);

    asserts_failed = u_microstepper_top.u_microstep_control.u_assertions.shoot_fails;
    asserts_failed += u_microstepper_top.u_microstep_control.u_assertions.fault_fails;
    asserts_failed += u_microstepper_top.u_microstep_control.u_assertions.disable_fails;
    $display("Summary: 5 tests, %0d check errors, %0d assertion failures",
             errors, asserts_failed);
    if (errors == 0 && asserts_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
source/stepper_pkg.sv
source/step_commutation.sv
source/coil_timers.sv
source/microstep_control.sv
source/microstepper_top.sv
sim/microstepper_assertions.sv
sim/tb_microstepper.sv

// ==== run.sh ====
#!/bin/sh
# Build the stepper testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_microstepper \
  -f compile.f -o tb_microstepper || exit 1
out=$(./obj_dir/tb_microstepper +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
